// File: rtl/argmin_pkg.sv
`default_nettype none

package argmin_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lane geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int LANES = 16;                // values per input word

  localparam int IDX_W = $clog2(LANES);     // 4 bits of lane index

  typedef logic [IDX_W-1:0] lane_idx_t;     // position of a lane in the word

  typedef logic [LANES-1:0] lane_tags_t;    // one tag bit per lane

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // value format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // double precision unless the top level says otherwise
  localparam int FLOAT_W_DEFAULT = 64;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pipeline shape
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int CMP_LATENCY = 3;           // key, compare, select

  localparam int TREE_LEVELS = $clog2(LANES); // 8, 4, 2, 1 leaves per level

endpackage

`default_nettype wire

// File: rtl/argmin_top.sv
`timescale 1ns/1ns
`default_nettype none

module argmin_top #(
  parameter int SIZE  = argmin_pkg::FLOAT_W_DEFAULT,
  parameter int DEPTH = 4
) (
  input  wire                                   aclk,
  input  wire                                   arst_n,
  input  wire  [argmin_pkg::LANES-1:0][SIZE-1:0] lane_data,
  input  wire  argmin_pkg::lane_tags_t          lane_tags,
  input  wire                                   lane_valid,
  output logic                                  lane_ready,
  output argmin_pkg::lane_idx_t                 result_index,
  output logic                                  result_tag,
  output logic                                  result_valid,
  input  wire                                   result_ready
);

  import argmin_pkg::*;

  // tree to FIFO
  lane_idx_t tree_index;
  logic      tree_tag;
  logic      tree_valid;
  logic      fifo_ready;   // not full, stalls the tree

  float_multi_argmin #(
    .SIZE(SIZE)
  ) argmin_tree_i (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .lane_data  (lane_data),
    .lane_tags  (lane_tags),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .min_index  (tree_index),
    .min_tag    (tree_tag),
    .min_valid  (tree_valid),
    .min_ready  (fifo_ready)
  );

  result_fifo #(
    .DEPTH(DEPTH)
  ) result_fifo_i (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .wr_index (tree_index),
    .wr_tag   (tree_tag),
    .wr_valid (tree_valid),
    .wr_ready (fifo_ready),
    .rd_index (result_index),
    .rd_tag   (result_tag),
    .rd_valid (result_valid),
    .rd_ready (result_ready)
  );

endmodule

`default_nettype wire

// File: rtl/float_argmin.sv
`timescale 1ns/1ns
`default_nettype none

module float_argmin #(
  parameter int SIZE = argmin_pkg::FLOAT_W_DEFAULT
) (
  input  wire                              aclk,
  input  wire                              arst_n,
  input  wire  [SIZE+argmin_pkg::IDX_W:0]  a_data,
  input  wire  [SIZE+argmin_pkg::IDX_W:0]  b_data,
  input  wire                              op_valid,
  output logic                             op_ready,
  output logic [SIZE+argmin_pkg::IDX_W:0]  min_data,
  output logic                             min_valid,
  input  wire                              min_ready
);

  import argmin_pkg::*;

  localparam int CAND_W = SIZE + IDX_W + 1;  // value, index, tag

  typedef logic [SIZE-1:0]   key_t;
  typedef logic [CAND_W-1:0] cand_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // total order on the raw bit pattern
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic key_t order_key(input key_t value);
    if (value[SIZE-1]) begin
      order_key = ~value;                    // negative, larger magnitude sorts lower
    end else begin
      order_key = {1'b1, value[SIZE-2:0]};   // positive, above every negative
    end
  endfunction

  logic [CMP_LATENCY-1:0] stage_vld;
  logic                   advance;

  key_t  a_key_q;
  key_t  b_key_q;
  cand_t a_s1_q;
  cand_t b_s1_q;

  logic  pick_b_q;
  cand_t a_s2_q;
  cand_t b_s2_q;

  cand_t min_q;

  // whole pipe moves when the last slot is empty or drained
  assign advance   = ~stage_vld[CMP_LATENCY-1] | min_ready;
  assign op_ready  = advance;
  assign min_valid = stage_vld[CMP_LATENCY-1];
  assign min_data  = min_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // valid bits, one per stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      stage_vld <= '0;
    end else if (advance) begin
      stage_vld <= {stage_vld[CMP_LATENCY-2:0], op_valid};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge aclk) begin
    if (advance) begin
      // stage 1
      a_key_q <= order_key(a_data[CAND_W-1 -: SIZE]);
      b_key_q <= order_key(b_data[CAND_W-1 -: SIZE]);
      a_s1_q  <= a_data;
      b_s1_q  <= b_data;

      // stage 2
      pick_b_q <= (b_key_q < a_key_q);       // tie keeps a, the lower index
      a_s2_q   <= a_s1_q;
      b_s2_q   <= b_s1_q;

      // stage 3
      min_q <= pick_b_q ? b_s2_q : a_s2_q;
    end
  end

endmodule

`default_nettype wire

// File: rtl/float_multi_argmin.sv
`timescale 1ns/1ns
`default_nettype none

module float_multi_argmin #(
  parameter int SIZE = argmin_pkg::FLOAT_W_DEFAULT
) (
  input  wire                                   aclk,
  input  wire                                   arst_n,
  input  wire  [argmin_pkg::LANES-1:0][SIZE-1:0] lane_data,
  input  wire  argmin_pkg::lane_tags_t          lane_tags,
  input  wire                                   lane_valid,
  output logic                                  lane_ready,
  output argmin_pkg::lane_idx_t                 min_index,
  output logic                                  min_tag,
  output logic                                  min_valid,
  input  wire                                   min_ready
);

  import argmin_pkg::*;

  localparam int CAND_W = SIZE + IDX_W + 1;

  typedef logic [CAND_W-1:0] cand_t;

  // nodes numbered as a heap, 1 is the root, 8..15 see the lanes
  cand_t node_a    [1:LANES-1];
  cand_t node_b    [1:LANES-1];
  cand_t node_cand [1:LANES-1];

  logic [LANES-1:1]   node_op_vld;   // pair offered to a node
  logic [LANES-1:1]   node_vld;      // node output holds a result
  logic [LANES-1:1]   node_rdy;      // node can take a pair
  logic [LANES-1:1]   node_down;     // downstream takes the node result
  logic [LANES/2-1:1] node_take;     // inner node accepts its children

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ready, root first
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    node_down = '0;
    node_take = '0;
    for (int n = 1; n < LANES; n++) begin
      if (n == 1) begin
        node_down[n] = min_ready;
      end else begin
        node_down[n] = node_take[n/2];       // siblings share the parent take
      end
      if (n < LANES/2) begin
        node_take[n] = (~node_vld[n] | node_down[n]) & node_vld[2*n] & node_vld[2*n+1];
      end
    end
  end

  assign lane_ready = &node_rdy[LANES-1:LANES/2];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tree
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar lvl = 1; lvl <= TREE_LEVELS; lvl++) begin : g_level
    for (genvar k = 0; k < (LANES >> lvl); k++) begin : g_node
      localparam int N = (1 << (TREE_LEVELS - lvl)) + k;

      if (lvl == 1) begin : g_leaf
        assign node_a[N]      = {lane_data[2*k],   lane_idx_t'(2*k),   lane_tags[2*k]};
        assign node_b[N]      = {lane_data[2*k+1], lane_idx_t'(2*k+1), lane_tags[2*k+1]};
        assign node_op_vld[N] = lane_valid & lane_ready;
      end else begin : g_inner
        assign node_a[N]      = node_cand[2*N];
        assign node_b[N]      = node_cand[2*N+1];
        assign node_op_vld[N] = node_vld[2*N] & node_vld[2*N+1];  // join of both children
      end

      float_argmin #(
        .SIZE(SIZE)
      ) cmp_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .a_data    (node_a[N]),
        .b_data    (node_b[N]),
        .op_valid  (node_op_vld[N]),
        .op_ready  (node_rdy[N]),
        .min_data  (node_cand[N]),
        .min_valid (node_vld[N]),
        .min_ready (node_down[N])
      );
    end
  end

  // root result, value field dropped
  assign min_index = node_cand[1][IDX_W:1];
  assign min_tag   = node_cand[1][0];
  assign min_valid = node_vld[1];

endmodule

`default_nettype wire

// File: rtl/result_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module result_fifo #(
  parameter int DEPTH = 4
) (
  input  wire                         aclk,
  input  wire                         arst_n,
  input  wire  argmin_pkg::lane_idx_t wr_index,
  input  wire                         wr_tag,
  input  wire                         wr_valid,
  output logic                        wr_ready,
  output argmin_pkg::lane_idx_t       rd_index,
  output logic                        rd_tag,
  output logic                        rd_valid,
  input  wire                         rd_ready
);

  import argmin_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;

  lane_idx_t idx_mem [DEPTH];
  logic      tag_mem [DEPTH];

  ptr_t             wr_ptr;
  ptr_t             rd_ptr;
  logic [CNT_W-1:0] fill;
  logic             do_wr;
  logic             do_rd;

  function automatic ptr_t next_ptr(input ptr_t p);
    if (p == PTR_W'(DEPTH - 1)) begin
      next_ptr = '0;                         // wrap, depth need not be a power of 2
    end else begin
      next_ptr = p + 1'b1;
    end
  endfunction

  assign wr_ready = (fill != CNT_W'(DEPTH)); // not full
  assign rd_valid = (fill != '0);
  assign do_wr    = wr_valid & wr_ready;
  assign do_rd    = rd_valid & rd_ready;
  assign rd_index = idx_mem[rd_ptr];
  assign rd_tag   = tag_mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (do_wr) begin
      idx_mem[wr_ptr] <= wr_index;
      tag_mem[wr_ptr] <= wr_tag;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;               // idle or write through
      endcase
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the argmin testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_argmin_top -f tb.f -o sim_argmin \
  && out=$(./obj_dir/sim_argmin) \
  ; echo "$out" \
  && echo "$out" | grep -q "SIMULATION PASSED" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

// File: tb.f
rtl/argmin_pkg.sv
rtl/float_argmin.sv
rtl/float_multi_argmin.sv
rtl/result_fifo.sv
rtl/argmin_top.sv
verif/argmin_checker.sv
verif/tb_argmin_top.sv

// File: verif/argmin_checker.sv
`timescale 1ns/1ns
`default_nettype none

module argmin_checker #(
  parameter int SIZE = 32
) (
  input  wire                                    aclk,
  input  wire                                    arst_n,
  input  wire  [argmin_pkg::LANES-1:0][SIZE-1:0] lane_data,
  input  wire  argmin_pkg::lane_tags_t           lane_tags,
  input  wire                                    lane_valid,
  input  wire                                    lane_ready,
  input  wire  argmin_pkg::lane_idx_t            exp_index,
  input  wire                                    exp_check,
  input  wire  argmin_pkg::lane_idx_t            result_index,
  input  wire                                    result_tag,
  input  wire                                    result_valid,
  input  wire                                    result_ready,
  input  wire                                    streaming,
  output int                                     errors,
  output int                                     pending,
  output int                                     results
);

  import argmin_pkg::*;

  localparam int FIRST_LATENCY = 13;   // lane accept to result_valid

  logic [IDX_W:0] exp_q [$];            // index, then tag
  int             cycle;
  int             first_accept;
  bit             first_seen;
  bit             prev_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference ordering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [SIZE-1:0] key_of(input logic [SIZE-1:0] v);
    if (v[SIZE-1]) begin
      return ~v;
    end
    return v ^ {1'b1, {(SIZE-1){1'b0}}};
  endfunction

  function automatic lane_idx_t min_lane(input logic [LANES-1:0][SIZE-1:0] d);
    int best;
    best = 0;
    for (int i = 1; i < LANES; i++) begin
      if (key_of(d[i]) < key_of(d[best])) begin
        best = i;                       // strict, lower lane keeps a tie
      end
    end
    return lane_idx_t'(best);
  endfunction

  always @(posedge aclk) begin
    lane_idx_t      want;
    logic [IDX_W:0] e;
    if (!arst_n) begin
      if (result_valid !== 1'b0 || lane_ready !== 1'b1) begin
        $display("** Error at %0t: reset state, result_valid %b lane_ready %b",
                 $time, result_valid, lane_ready);
        errors++;
      end
      cycle        = 0;
      first_accept = -1;
      first_seen   = 0;
      prev_valid   = 0;
      pending      = 0;
      exp_q.delete();
    end else begin
      cycle++;
      if (result_valid && !first_seen && first_accept >= 0) begin
        first_seen = 1;
        if (cycle - first_accept != FIRST_LATENCY) begin
          $display("** Error at %0t: first result after %0d cycles, expected %0d",
                   $time, cycle - first_accept, FIRST_LATENCY);
          errors++;
        end
      end
      if (streaming && prev_valid && !result_valid && pending > 0) begin
        $display("** Error at %0t: gap in result stream, %0d rows pending", $time, pending);
        errors++;
      end
      if (result_valid && result_ready) begin
        if (exp_q.size() == 0) begin
          $display("a result was delivered at %0t with no row pending", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          pending--;
          results++;
          if (result_index !== e[IDX_W:1] || result_tag !== e[0]) begin
            $display("** Error at %0t: result lane index %0d tag %b, expected lane %0d tag %b",
                     $time, result_index, result_tag, e[IDX_W:1], e[0]);
            errors++;
          end
        end
      end
      if (lane_valid && lane_ready) begin
        want = min_lane(lane_data);
        if (first_accept < 0) begin
          first_accept = cycle;
        end
        if (exp_check && want !== exp_index) begin
          $display("** Error at %0t: table lane index %0d, ordering rule gives lane %0d",
                   $time, exp_index, want);
          errors++;
        end
        exp_q.push_back({want, lane_tags[want]});
        pending++;
      end
      prev_valid = result_valid;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_argmin_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_argmin_top;

  import argmin_pkg::*;

  localparam int SIZE    = 32;
  localparam int DEPTH   = 4;
  localparam int TIMEOUT = 500;      // cycles per wait
  localparam int N_RAND  = 20;       // per random phase

  typedef struct packed {
    logic [31:0] base;
    logic [31:0] step;
    logic [31:0] low;
    logic [4:0]  low_a;              // 16 means no lane
    logic [4:0]  low_b;
    lane_tags_t  tags;
    lane_idx_t   exp;
  } row_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed rows
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  row_t rows [12] = '{
    '{32'h3f800000, 32'h00000100, 32'h3f000000, 5'd0,  5'd16, 16'h0000, 4'd0},
    '{32'h3f800000, 32'h00000100, 32'h3f000000, 5'd15, 5'd16, 16'hffff, 4'd15},
    '{32'h3f800000, 32'h00010000, 32'hbf800000, 5'd3,  5'd16, 16'haaaa, 4'd3},
    '{32'h00000000, 32'h00000000, 32'h80000000, 5'd5,  5'd16, 16'h5555, 4'd5},  // -0 below +0
    '{32'h7f800000, 32'h00000000, 32'h7f7fffff, 5'd9,  5'd16, 16'hffff, 4'd9},
    '{32'hc0000000, 32'h00000000, 32'hff800000, 5'd12, 5'd16, 16'h0000, 4'd12}, // -inf
    '{32'h40400000, 32'h00000000, 32'h3f000000, 5'd7,  5'd11, 16'haaaa, 4'd7},
    '{32'h40000000, 32'h00000000, 32'h40000000, 5'd16, 5'd16, 16'h5555, 4'd0},  // all equal
    '{32'hbf800000, 32'h00000010, 32'h00000000, 5'd16, 5'd16, 16'h0f0f, 4'd15},
    '{32'h00000000, 32'h00000000, 32'h80000000, 5'd14, 5'd6,  16'hffff, 4'd6},
    '{32'h42c80000, 32'h00001000, 32'hc2c80000, 5'd10, 5'd16, 16'h0000, 4'd10},
    '{32'h7fc00000, 32'h00000000, 32'h7f800000, 5'd13, 5'd16, 16'h3c3c, 4'd13}  // NaN above inf
  };

  logic                        aclk;
  logic                        arst_n;
  logic [LANES-1:0][SIZE-1:0]  lane_data;
  lane_tags_t                  lane_tags;
  logic                        lane_valid;
  logic                        lane_ready;
  lane_idx_t                   result_index;
  logic                        result_tag;
  logic                        result_valid;
  logic                        result_ready;
  lane_idx_t                   exp_index;
  logic                        exp_check;
  logic                        streaming;
  int                          errors;
  int                          pending;
  int                          results;
  int                          tb_errors;
  int                          ready_mode;    // 0 high, 1 random, 2 low
  bit                          stall_seen;
  logic [31:0]                 row_rng;
  logic [31:0]                 rdy_rng;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [LANES-1:0][SIZE-1:0] row_values(input row_t r);
    logic [LANES-1:0][SIZE-1:0] v;
    for (int i = 0; i < LANES; i++) begin
      if (i == r.low_a || i == r.low_b) begin
        v[i] = r.low;
      end else begin
        v[i] = r.base + i * r.step;
      end
    end
    return v;
  endfunction

  argmin_top #(
    .SIZE  (SIZE),
    .DEPTH (DEPTH)
  ) dut_i (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .lane_data    (lane_data),
    .lane_tags    (lane_tags),
    .lane_valid   (lane_valid),
    .lane_ready   (lane_ready),
    .result_index (result_index),
    .result_tag   (result_tag),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

  argmin_checker #(
    .SIZE(SIZE)
  ) checker_i (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .lane_data    (lane_data),
    .lane_tags    (lane_tags),
    .lane_valid   (lane_valid),
    .lane_ready   (lane_ready),
    .exp_index    (exp_index),
    .exp_check    (exp_check),
    .result_index (result_index),
    .result_tag   (result_tag),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .streaming    (streaming),
    .errors       (errors),
    .pending      (pending),
    .results      (results)
  );

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  always @(posedge aclk) begin
    case (ready_mode)
      0: result_ready <= 1'b1;
      1: begin
        rdy_rng = xorshift(rdy_rng);
        result_ready <= rdy_rng[0] | rdy_rng[1];   // about three in four
      end
      default: result_ready <= 1'b0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // drivers entered on a rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic fail_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic send_row(input logic [LANES-1:0][SIZE-1:0] vals, input lane_tags_t tags,
                          input lane_idx_t exp, input logic chk);
    int waited;
    waited = 0;
    lane_data  <= vals;
    lane_tags  <= tags;
    lane_valid <= 1'b1;
    exp_index  <= exp;
    exp_check  <= chk;
    @(posedge aclk);
    while (!lane_ready) begin
      if (ready_mode == 2) begin
        ready_mode <= 1;               // full so let it drain
        stall_seen = 1;
      end
      waited++;
      if (waited > TIMEOUT) fail_timeout("lane accept");
      @(posedge aclk);
    end
  endtask

  task automatic send_random;
    logic [LANES-1:0][SIZE-1:0] v;
    for (int i = 0; i < LANES; i++) begin
      row_rng = xorshift(row_rng);
      v[i] = row_rng;
    end
    v[row_rng[7:4]] = v[row_rng[3:0]]; // a duplicate in most rows
    row_rng = xorshift(row_rng);
    send_row(v, row_rng[15:0], '0, 1'b0);
  endtask

  task automatic wait_drain;
    int waited;
    waited = 0;
    lane_valid <= 1'b0;
    exp_check  <= 1'b0;
    @(negedge aclk);
    while (pending != 0) begin
      waited++;
      if (waited > TIMEOUT) fail_timeout("result drain");
      @(negedge aclk);
    end
    @(posedge aclk);
  endtask

  initial begin
    lane_data    = '0;
    lane_tags    = '0;
    lane_valid   = 1'b0;
    exp_index    = '0;
    exp_check    = 1'b0;
    streaming    = 1'b0;
    result_ready = 1'b1;
    ready_mode   = 0;
    stall_seen   = 0;
    tb_errors    = 0;
    row_rng      = 32'h66ca5796;
    rdy_rng      = xorshift(32'h66ca5796);
    arst_n       = 1'b1;
    #1 arst_n    = 1'b0;
    repeat (3) @(posedge aclk);
    arst_n <= 1'b1;
    @(posedge aclk);

    // single row for latency
    send_row(row_values(rows[0]), rows[0].tags, rows[0].exp, 1'b1);
    wait_drain();

    // back to back
    streaming <= 1'b1;
    for (int r = 1; r < 12; r++) begin
      send_row(row_values(rows[r]), rows[r].tags, rows[r].exp, 1'b1);
    end
    wait_drain();
    streaming <= 1'b0;

    ready_mode <= 1;
    repeat (N_RAND) send_random();
    wait_drain();

    // hold result_ready low until the tree backs up
    ready_mode <= 2;
    repeat (N_RAND) send_random();
    if (!stall_seen) begin
      $display("lane_ready never dropped while result_ready was held low");
      tb_errors++;
      ready_mode <= 1;
    end
    wait_drain();
    ready_mode <= 0;
    repeat (4) @(posedge aclk);

    if (results != 12 + 2 * N_RAND) begin
      $display("expected %0d results but %0d were delivered", 12 + 2 * N_RAND, results);
      tb_errors++;
    end
    $display("checker errors %0d, testbench errors %0d, results %0d",
             errors, tb_errors, results);
    if (errors + tb_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
